/* files.f */
logic/lsq_pkg.sv
logic/sq_dispatch.sv
logic/sq_entry.sv
logic/sq_retire.sv
logic/store_queue.sv
tb/tb_store_queue.sv

/* Makefile */
# Verilator build, run and lint for the store queue testbench

VERILATOR ?= verilator
TOP       ?= tb_store_queue
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TESTBENCH PASSED
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

SRCS := $(wildcard logic/*.sv tb/*.sv)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/tb_store_queue.sv */
/*
 * Store queue testbench
 * Clock, reset, LCG stimulus, Wishbone memory responder,
 * reference model with output compare, and watchdog
 */
`timescale 1ns/1ps

module tb_store_queue;
	import lsq_pkg::*;

	localparam int                   TEST_OPS = 80;
	localparam int                   LIMIT_NS = (TEST_OPS * 20 + 100) * 10;
	localparam logic [ROB_IDX_W-1:0] PARK_ROB = 5'd31;    // Never given to a store

	typedef struct packed {
		logic [DATA_W-1:0]    opa;
		logic [DATA_W-1:0]    off;
		logic [DATA_W-1:0]    data;
		logic [ROB_IDX_W-1:0] rob;
	} exp_store_t;

	logic                 clock;
	logic                 reset;
	dispatch_t            dispatch;
	cdb_t                 cdb;
	logic [ROB_IDX_W-1:0] rob_head;
	logic                 flush;
	logic                 wb_ack;
	result_t              result;
	wb_req_t              wb;
	logic                 store_done;
	logic [ROB_IDX_W-1:0] store_done_rob;
	logic                 full;

	logic [31:0]          stim_state = 32'hdca;
	logic [31:0]          ack_state  = 32'hdca;
	logic                 commit_en;
	logic [ROB_IDX_W-1:0] rob_count;
	result_t              exp_results [$];
	exp_store_t           exp_stores [$];   // Dispatched, not yet written
	wb_req_t              mem_writes [$];   // Recorded by the responder
	logic [ROB_IDX_W-1:0] done_q [$];

	store_queue u_store_queue (.*);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////
	function automatic logic [31:0] lcg_next(inout logic [31:0] state);
		state = state * 32'd1664525 + 32'd1013904223;
		return state;
	endfunction

	function automatic logic [DATA_W-1:0] rand64();
		logic [DATA_W-1:0] v;
		v[63:32] = lcg_next(stim_state);
		v[31:0]  = lcg_next(stim_state);
		return v;
	endfunction

	function automatic result_t expected_result(input dispatch_t d);
		result_t r;
		r.valid   = 1'b1;
		r.tag     = d.dest_tag;
		r.value   = d.opa + d.opb;          // Address add
		r.rob_idx = d.rob_idx;
		return r;
	endfunction

	function automatic wb_req_t expected_write(input exp_store_t s);
		wb_req_t w;
		w.cyc = 1'b1;
		w.stb = 1'b1;
		w.we  = 1'b1;
		w.adr = s.opa + s.off;
		w.dat = s.data;
		return w;
	endfunction

	task automatic stop_run(input string line);
		$display("%s", line);
		$display("TESTBENCH FAILED");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic check_result(input result_t got, input result_t want);
		if (got !== want)
			stop_run($sformatf("Error at %0t: LDA result %h, expected %h", $time, got, want));
	endtask

	task automatic check_write(input wb_req_t got, input wb_req_t want);
		if (got !== want)
			stop_run($sformatf("Error at %0t: write adr %h dat %h, expected adr %h dat %h",
				$time, got.adr, got.dat, want.adr, want.dat));
	endtask

	task automatic check_done(input logic [ROB_IDX_W-1:0] got, input logic [ROB_IDX_W-1:0] want);
		if (got !== want)
			stop_run($sformatf("Error at %0t: store_done ROB %0d, expected %0d", $time, got, want));
	endtask

	// Outputs sampled 1 ns after the falling edge
	initial begin : compare_outputs
		exp_store_t want;
		logic       lda_due;                        // LDA dispatched the cycle before
		lda_due = 1'b0;
		forever begin
			@(negedge clock);
			#1;
			if (!reset) begin
				if (result.valid && !lda_due)
					stop_run("LDA result appeared with no LDA dispatched the cycle before");
				else if (!result.valid && lda_due)
					stop_run("LDA result missing in the cycle after its dispatch");
				else if (lda_due)
					check_result(result, exp_results.pop_front());
			end
			lda_due = (exp_results.size() != 0);
			while (mem_writes.size() != 0) begin
				if (exp_stores.size() == 0)
					stop_run("Memory write seen for a store that should never be written");
				want = exp_stores.pop_front();
				check_write(mem_writes.pop_front(), expected_write(want));
				done_q.push_back(want.rob);
			end
			if (!reset && store_done) begin
				if (done_q.size() == 0)
					stop_run("store_done pulsed with no finished write");
				check_done(store_done_rob, done_q.pop_front());
			end
		end
	end

	// Slave acknowledges 0 to 3 cycles after the strobe
	initial begin : memory_responder
		int delay;
		wb_ack = 1'b0;
		forever begin
			@(negedge clock);
			wb_ack = 1'b0;
			if (!reset && wb.cyc && wb.stb) begin
				delay = int'((lcg_next(ack_state) >> 16) % 32'd4);
				repeat (delay) @(negedge clock);
				mem_writes.push_back(wb);
				wb_ack = 1'b1;
			end
		end
	end

	initial begin : watchdog
		#(LIMIT_NS);
		stop_run("Watchdog timeout: the tests did not finish in time");
	end

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////
	task automatic step();
		@(negedge clock);
		dispatch = '0;
		cdb      = '0;
		flush    = 1'b0;
		rob_head = (commit_en && exp_stores.size() != 0) ? exp_stores[0].rob : PARK_ROB;
	endtask

	task automatic send_lda();
		logic [31:0] rnd;
		step();
		rnd                 = lcg_next(stim_state);
		dispatch.valid      = 1'b1;
		dispatch.op         = OP_LDA;
		dispatch.opa        = rand64();
		dispatch.opb        = rand64();
		dispatch.opb_valid  = 1'b1;
		dispatch.rega_valid = 1'b1;
		dispatch.rob_idx    = rnd[20:16];
		dispatch.dest_tag   = rnd[29:24];
		exp_results.push_back(expected_result(dispatch));
	endtask

	// Offset and data go out as tags when not ready
	task automatic send_store(input logic [DATA_W-1:0] opa, input logic [DATA_W-1:0] off,
		input logic [DATA_W-1:0] data, input logic off_ready, input logic data_ready,
		input logic [TAG_W-1:0] off_tag, input logic [TAG_W-1:0] data_tag);
		exp_store_t s;
		step();
		while (full)
			step();
		dispatch.valid      = 1'b1;
		dispatch.op         = OP_STQ;
		dispatch.opa        = opa;
		dispatch.opb        = off_ready ? off : DATA_W'(off_tag);
		dispatch.opb_valid  = off_ready;
		dispatch.rega       = data_ready ? data : DATA_W'(data_tag);
		dispatch.rega_valid = data_ready;
		dispatch.rob_idx    = rob_count;
		s.opa  = opa;
		s.off  = off;
		s.data = data;
		s.rob  = rob_count;
		exp_stores.push_back(s);
		rob_count = (rob_count == 5'd30) ? 5'd0 : rob_count + 5'd1;
	endtask

	task automatic send_ready_store();
		send_store(rand64(), rand64(), rand64(), 1'b1, 1'b1, '0, '0);
	endtask

	task automatic broadcast(input logic [TAG_W-1:0] tag, input logic [DATA_W-1:0] value);
		step();
		cdb.valid = 1'b1;
		cdb.tag   = tag;
		cdb.value = value;
	endtask

	task automatic no_write_cycles(input int n);
		repeat (n) begin
			step();
			if (wb.cyc)
				stop_run("Wishbone cycle started for a store not ready or not committed");
		end
	endtask

	task automatic drain();
		while (exp_stores.size() != 0 || done_q.size() != 0)
			step();
		step();
	endtask

	initial begin : stimulus
		logic [DATA_W-1:0] off_val;
		logic [DATA_W-1:0] dat_val;
		dispatch  = '0;
		cdb       = '0;
		rob_head  = PARK_ROB;
		flush     = 1'b0;
		reset     = 1'b1;
		commit_en = 1'b0;
		rob_count = '0;
		repeat (2) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		if (result.valid || wb.cyc || wb.stb || store_done || full)
			stop_run($sformatf("Error at %0t: outputs not idle after reset", $time));

		repeat (10) send_lda();

		commit_en = 1'b1;
		repeat (12) begin
			send_ready_store();
			send_lda();
		end
		drain();

		// Both operands from later broadcasts
		off_val = rand64();
		dat_val = rand64();
		send_store(rand64(), off_val, dat_val, 1'b0, 1'b0, 6'd12, 6'd40);
		no_write_cycles(3);
		broadcast(6'd12, off_val);
		no_write_cycles(3);
		broadcast(6'd40, dat_val);
		drain();

		// Offset broadcast in the dispatch cycle
		off_val = rand64();
		dat_val = rand64();
		send_store(rand64(), off_val, dat_val, 1'b0, 1'b0, 6'd7, 6'd33);
		cdb.valid = 1'b1;
		cdb.tag   = 6'd7;
		cdb.value = off_val;
		no_write_cycles(2);
		broadcast(6'd33, dat_val);
		drain();

		// Uncommitted stores fill the queue
		commit_en = 1'b0;
		repeat (SQ_DEPTH) send_ready_store();
		step();
		if (!full)
			stop_run($sformatf("Error at %0t: full low with every entry in use", $time));
		no_write_cycles(5);
		commit_en = 1'b1;
		drain();

		// Flush a full queue with one write in flight and an LDA in the flush cycle
		send_ready_store();
		step();
		while (!wb.cyc)
			step();
		commit_en = 1'b0;
		repeat (SQ_DEPTH) send_ready_store();
		repeat (SQ_DEPTH) void'(exp_stores.pop_back());
		send_lda();
		flush = 1'b1;
		step();
		if (full)
			stop_run($sformatf("Error at %0t: full high after flush", $time));
		commit_en = 1'b1;
		repeat (4) send_ready_store();
		drain();

		if (exp_results.size() != 0 || mem_writes.size() != 0 || done_q.size() != 0) begin
			stop_run("Run ended with expected outputs that never appeared");
		end else begin
			$display("TESTBENCH PASSED");
			$finish;
		end
	end

endmodule

/* logic/store_queue.sv */
/*
 * Store queue top level
 * Dispatcher, array of queue entries and retire unit
 */
`timescale 1ns/1ps

module store_queue (
	input  logic                          clock,
	input  logic                          reset,
	input  lsq_pkg::dispatch_t            dispatch,
	input  lsq_pkg::cdb_t                 cdb,
	input  logic [lsq_pkg::ROB_IDX_W-1:0] rob_head,
	input  logic                          flush,
	input  logic                          wb_ack,
	output lsq_pkg::result_t              result,
	output lsq_pkg::wb_req_t              wb,
	output logic                          store_done,
	output logic [lsq_pkg::ROB_IDX_W-1:0] store_done_rob,
	output logic                          full
);
	import lsq_pkg::*;

	logic [SQ_DEPTH-1:0] write_en;    // From dispatch, one-hot
	logic [SQ_DEPTH-1:0] free_en;     // From retire, one-hot
	logic [SQ_DEPTH-1:0] slot_valid;
	logic [SQ_IDX_W-1:0] head;
	sq_slot_t            slots [SQ_DEPTH];

	sq_dispatch u_dispatch (
		.clock      (clock),
		.reset      (reset),
		.dispatch   (dispatch),
		.flush      (flush),
		.slot_valid (slot_valid),
		.head       (head),
		.write_en   (write_en),
		.result     (result),
		.full       (full)
	);

	//////////////////////////////////////////////////
	// Queue entries
	//////////////////////////////////////////////////
	for (genvar i = 0; i < SQ_DEPTH; i++) begin : g_entry
		sq_entry u_entry (
			.clock    (clock),
			.reset    (reset),
			.flush    (flush),
			.write_en (write_en[i]),
			.free_en  (free_en[i]),
			.dispatch (dispatch),
			.cdb      (cdb),
			.slot     (slots[i])
		);
		assign slot_valid[i] = slots[i].valid;
	end

	sq_retire u_retire (
		.clock          (clock),
		.reset          (reset),
		.slots          (slots),
		.rob_head       (rob_head),
		.wb_ack         (wb_ack),
		.head           (head),
		.free_en        (free_en),
		.wb             (wb),
		.store_done     (store_done),
		.store_done_rob (store_done_rob)
	);

endmodule

/* logic/sq_retire.sv */
/*
 * Store queue retire side
 * Head pointer, commit check against the ROB head,
 * Wishbone classic write cycle and store completion report
 */
`timescale 1ns/1ps

module sq_retire (
	input  logic                          clock,
	input  logic                          reset,
	input  lsq_pkg::sq_slot_t             slots [lsq_pkg::SQ_DEPTH],
	input  logic [lsq_pkg::ROB_IDX_W-1:0] rob_head,
	input  logic                          wb_ack,
	output logic [lsq_pkg::SQ_IDX_W-1:0]  head,
	output logic [lsq_pkg::SQ_DEPTH-1:0]  free_en,
	output lsq_pkg::wb_req_t              wb,
	output logic                          store_done,
	output logic [lsq_pkg::ROB_IDX_W-1:0] store_done_rob
);
	import lsq_pkg::*;

	typedef enum logic {
		WB_IDLE,
		WB_WRITING
	} bus_state_e;

	bus_state_e           state;
	sq_slot_t             head_slot;
	logic                 start;
	logic                 ack_seen;
	logic [DATA_W-1:0]    write_adr;
	logic [DATA_W-1:0]    write_dat;
	logic [ROB_IDX_W-1:0] write_rob;

	//////////////////////////////////////////////////
	// Commit check on the head entry
	//////////////////////////////////////////////////
	assign head_slot = slots[head];
	assign start     = (state == WB_IDLE) && head_slot.valid
	                   && head_slot.opb_ready && head_slot.data_ready
	                   && (head_slot.rob_idx == rob_head);
	assign ack_seen  = (state == WB_WRITING) && wb_ack;

	assign free_en = start ? (SQ_DEPTH'(1) << head) : '0;   // Entry leaves as the bus starts

	always_ff @(posedge clock) begin
		if (reset) begin
			state      <= WB_IDLE;
			head       <= '0;
			store_done <= 1'b0;
		end else begin
			store_done <= ack_seen;
			if (start) begin
				state <= WB_WRITING;
				head  <= head + 1'b1;
			end else if (ack_seen) begin
				state <= WB_IDLE;
			end
		end
	end

	// Write latched at start, held until the ack
	always_ff @(posedge clock) begin
		if (start) begin
			write_adr <= head_slot.opa + head_slot.opb;
			write_dat <= head_slot.data;
			write_rob <= head_slot.rob_idx;
		end
	end

	//////////////////////////////////////////////////
	// Wishbone classic master
	//////////////////////////////////////////////////
	always_comb begin
		wb.cyc = (state == WB_WRITING);
		wb.stb = (state == WB_WRITING);
		wb.we  = (state == WB_WRITING);
		wb.adr = write_adr;
		wb.dat = write_dat;
	end

	assign store_done_rob = write_rob;        // Stable until the next start

	// Address and data must hold while the slave stalls
	a_wb_stable: assert property (
		@(posedge clock) disable iff (reset)
		wb.stb && !wb_ack |=> $stable(wb.adr) && $stable(wb.dat)
	) else $error("Wishbone address or data changed during a stalled write");

endmodule

/* logic/sq_entry.sv */
/*
 * One store queue slot
 * Holds a store and picks up a missing offset or data value
 * from the CDB, also in the cycle it is written
 */
`timescale 1ns/1ps

module sq_entry (
	input  logic               clock,
	input  logic               reset,
	input  logic               flush,
	input  logic               write_en,
	input  logic               free_en,
	input  lsq_pkg::dispatch_t dispatch,
	input  lsq_pkg::cdb_t      cdb,
	output lsq_pkg::sq_slot_t  slot
);
	import lsq_pkg::*;

	sq_slot_t nxt;

	// Tag match on a broadcast for an operand still outstanding
	function automatic logic cdb_hit(
		input cdb_t              bus,
		input logic [DATA_W-1:0] operand,
		input logic              ready
	);
		return bus.valid && !ready && (bus.tag == operand[TAG_W-1:0]);
	endfunction

	always_comb begin
		nxt = slot;
		if (write_en) begin
			nxt.valid      = 1'b1;
			nxt.opa        = dispatch.opa;
			nxt.opb        = dispatch.opb;
			nxt.opb_ready  = dispatch.opb_valid;
			nxt.data       = dispatch.rega;
			nxt.data_ready = dispatch.rega_valid;
			nxt.rob_idx    = dispatch.rob_idx;
		end else if (free_en) begin
			nxt.valid = 1'b0;                       // Store handed to the bus
		end
		if (flush) begin
			nxt.valid = 1'b0;
		end

		// Operand capture, works on the incoming store as well
		if (cdb_hit(cdb, nxt.opb, nxt.opb_ready)) begin
			nxt.opb       = cdb.value;
			nxt.opb_ready = 1'b1;
		end
		if (cdb_hit(cdb, nxt.data, nxt.data_ready)) begin
			nxt.data       = cdb.value;
			nxt.data_ready = 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		slot <= nxt;
		if (reset) begin
			slot.valid <= 1'b0;
		end
	end

	// Dispatch only writes into a free slot
	a_write_free_slot: assert property (
		@(posedge clock) disable iff (reset) write_en |-> !slot.valid
	) else $error("write strobe on an occupied store queue entry");

endmodule

/* logic/sq_dispatch.sv */
/*
 * Store queue dispatch side
 * Opcode decode, tail pointer and entry write strobes,
 * LDA address result register and full flag
 */
`timescale 1ns/1ps

module sq_dispatch (
	input  logic                         clock,
	input  logic                         reset,
	input  lsq_pkg::dispatch_t           dispatch,
	input  logic                         flush,
	input  logic [lsq_pkg::SQ_DEPTH-1:0] slot_valid,
	input  logic [lsq_pkg::SQ_IDX_W-1:0] head,
	output logic [lsq_pkg::SQ_DEPTH-1:0] write_en,
	output lsq_pkg::result_t             result,
	output logic                         full
);
	import lsq_pkg::*;

	logic                is_lda;
	logic                is_stq;
	logic                accept;
	logic [SQ_IDX_W-1:0] tail;

	//////////////////////////////////////////////////
	// Decode
	//////////////////////////////////////////////////
	assign is_lda = dispatch.valid && (dispatch.op == OP_LDA);
	assign is_stq = dispatch.valid && (dispatch.op == OP_STQ);

	assign full   = slot_valid[tail];             // Tail slot still occupied
	assign accept = is_stq && !full && !flush;    // Flush drops a store in the same cycle

	// One-hot strobe of the tail slot
	assign write_en = accept ? (SQ_DEPTH'(1) << tail) : '0;

	always_ff @(posedge clock) begin
		if (reset) begin
			tail <= '0;
		end else if (flush) begin
			tail <= head;                           // Queue empties back to the head
		end else if (accept) begin
			tail <= tail + 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// LDA result, one cycle after dispatch
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			result.valid <= 1'b0;
		end else begin
			result.valid <= is_lda;
		end
		if (is_lda) begin
			result.value   <= dispatch.opa + dispatch.opb;
			result.tag     <= dispatch.dest_tag;
			result.rob_idx <= dispatch.rob_idx;
		end
	end

	// Producer holds stores while the tail entry is still in use
	a_no_store_when_full: assert property (
		@(posedge clock) disable iff (reset) !(is_stq && full)
	) else $error("store dispatched while store queue full");

endmodule

/* logic/lsq_pkg.sv */
/*
 * Store queue shared definitions
 * Sizes, memory opcode enum, and the dispatch, CDB, result,
 * queue slot and Wishbone request structs
 */
package lsq_pkg;

	//////////////////////////////////////////////////
	// Sizes
	//////////////////////////////////////////////////
	localparam int SQ_DEPTH  = 8;
	localparam int SQ_IDX_W  = $clog2(SQ_DEPTH);
	localparam int DATA_W    = 64;               // Data and address
	localparam int TAG_W     = 6;                // 64 physical registers
	localparam int ROB_IDX_W = 5;                // 32 ROB entries

	// Alpha opcode numbers, anything else is a no-op
	typedef enum logic [5:0] {
		OP_NONE = 6'd0,
		OP_LDA  = 6'd8,
		OP_STQ  = 6'd45
	} mem_op_e;

	//////////////////////////////////////////////////
	// Buses
	//////////////////////////////////////////////////
	typedef struct packed {
		logic                 valid;
		mem_op_e              op;
		logic [DATA_W-1:0]    opa;        // Base, always valid
		logic [DATA_W-1:0]    opb;        // Offset, or tag in low bits
		logic                 opb_valid;
		logic [DATA_W-1:0]    rega;       // Store data, or tag in low bits
		logic                 rega_valid;
		logic [ROB_IDX_W-1:0] rob_idx;
		logic [TAG_W-1:0]     dest_tag;
	} dispatch_t;

	typedef struct packed {
		logic              valid;
		logic [TAG_W-1:0]  tag;
		logic [DATA_W-1:0] value;
	} cdb_t;

	// LDA result broadcast
	typedef struct packed {
		logic                 valid;
		logic [TAG_W-1:0]     tag;
		logic [DATA_W-1:0]    value;
		logic [ROB_IDX_W-1:0] rob_idx;
	} result_t;

	typedef struct packed {
		logic                 valid;
		logic [DATA_W-1:0]    opa;
		logic [DATA_W-1:0]    opb;
		logic                 opb_ready;
		logic [DATA_W-1:0]    data;
		logic                 data_ready;
		logic [ROB_IDX_W-1:0] rob_idx;
	} sq_slot_t;

	// Wishbone classic master outputs, write only
	typedef struct packed {
		logic              cyc;
		logic              stb;
		logic              we;
		logic [DATA_W-1:0] adr;
		logic [DATA_W-1:0] dat;
	} wb_req_t;

endpackage
